// File: verilog/ssa_pkg.sv
// shared flit layout and mesh port numbering for the straight allocator
package ssa_pkg;

    // flit layout
    localparam int FLIT_W   = 32;
    localparam int HDR_BIT  = 31;
    localparam int TAIL_BIT = 30;
    localparam int VC_MSB   = 29;  // one-hot vc field runs down from here, V <= 27
    localparam int PORT_W   = 3;   // header destination sits in the low bits

    // top level defaults
    localparam int P_DEF = 5;
    localparam int V_DEF = 2;

    // mesh port indices
    localparam logic [PORT_W-1:0] PORT_LOCAL = 3'd0;
    localparam logic [PORT_W-1:0] PORT_EAST  = 3'd1;
    localparam logic [PORT_W-1:0] PORT_NORTH = 3'd2;
    localparam logic [PORT_W-1:0] PORT_WEST  = 3'd3;
    localparam logic [PORT_W-1:0] PORT_SOUTH = 3'd4;

    // port across the router from the given one
    // a return value equal to p means no straight port (local)
    function automatic logic [PORT_W-1:0] straight_port(input int p, input int port);
        logic [PORT_W-1:0] sp;
        sp = PORT_W'(p);
        if (p == 5) begin
            case (port)
                PORT_EAST:  sp = PORT_WEST;
                PORT_WEST:  sp = PORT_EAST;
                PORT_NORTH: sp = PORT_SOUTH;
                PORT_SOUTH: sp = PORT_NORTH;
                default:    sp = PORT_W'(p);
            endcase
        end else if (p == 3) begin
            // 3-port router packs west into index 2
            case (port)
                1:       sp = PORT_W'(2);
                2:       sp = PORT_W'(1);
                default: sp = PORT_W'(p);
            endcase
        end
        return sp;
    endfunction

endpackage

// File: verilog/ssa_flit_decode.sv
`timescale 1ns/1ps

// pulls the control fields out of the flit arriving on one input port
module ssa_flit_decode
    import ssa_pkg::*;
#(
    parameter int V       = V_DEF,
    parameter int SS_PORT = PORT_WEST
) (
    input  logic [FLIT_W-1:0] flit_in_i,
    input  logic              flit_in_wr_i,
    output wire               hdr_flg_o,
    output wire               tail_flg_o,
    output wire               single_flit_pck_o,
    output wire  [V-1:0]      vc_num_o,
    output wire               hdr_to_ss_o
);

    localparam logic [PORT_W-1:0] SS_CODE = PORT_W'(SS_PORT);

    wire [PORT_W-1:0] hdr_dest_port;

    assign hdr_flg_o  = flit_in_i[HDR_BIT];
    assign tail_flg_o = flit_in_i[TAIL_BIT];

    // header and tail together, packets may be one flit long
    assign single_flit_pck_o = hdr_flg_o & tail_flg_o;

    assign vc_num_o = flit_in_i[VC_MSB -: V];  // one-hot

    // destination field only carries a port in header flits
    assign hdr_dest_port = flit_in_i[PORT_W-1:0];

    // header bound for the port straight across
    assign hdr_to_ss_o = flit_in_wr_i & hdr_flg_o & (hdr_dest_port == SS_CODE);

endmodule

// File: verilog/ssa_vc_check.sv
`timescale 1ns/1ps

// bypass check for every vc of one input port against its straight output port
module ssa_vc_check
    import ssa_pkg::*;
#(
    parameter int V       = V_DEF,
    parameter int SS_PORT = PORT_WEST
) (
    // from the flit decoder
    input  logic                  hdr_flg_i,
    input  logic                  tail_flg_i,
    input  logic                  single_flit_pck_i,
    input  logic [V-1:0]          vc_num_i,
    input  logic                  hdr_to_ss_i,
    input  logic                  flit_in_wr_i,

    // router state
    input  logic                  any_ivc_sw_request_granted_i,
    input  logic                  any_ovc_granted_in_ss_port_i,
    input  logic [V-1:0]          ovc_avail_ss_i,   // straight port ovcs
    input  logic [V-1:0]          ovc_full_ss_i,
    input  logic [V-1:0]          ivc_req_i,        // this input's ivcs
    input  logic [V-1:0]          ovc_is_assigned_i,
    input  logic [V*V-1:0]        assigned_ovc_num_i,
    input  logic [V*PORT_W-1:0]   ivc_dest_port_i,

    output wire  [V-1:0]          ivc_num_getting_sw_grant_o,
    output wire  [V-1:0]          ivc_num_getting_ovc_grant_o,
    output wire  [V-1:0]          ivc_reset_o,
    output wire  [V-1:0]          decreased_credit_o,
    output wire  [V-1:0]          ovc_allocated_o,
    output wire  [V-1:0]          ovc_released_o,
    output wire  [V*V-1:0]        granted_ovc_num_o
);

    localparam logic [PORT_W-1:0] SS_CODE = PORT_W'(SS_PORT);

    wire port_free;
    wire credit_pre;
    wire alloc_pre;
    wire release_pre;

    // no ivc of this input switch granted, straight output not taken
    assign port_free = ~(any_ivc_sw_request_granted_i | any_ovc_granted_in_ss_port_i);

    // everything but a header that turns away uses a straight slot
    assign credit_pre = ~(hdr_flg_i & ~hdr_to_ss_i);
    assign alloc_pre  = hdr_flg_i & hdr_to_ss_i;

    // a single flit packet frees its vc as soon as it leaves
    assign release_pre = single_flit_pck_i ? credit_pre : tail_flg_i;

    genvar v, w;
    generate
        for (v = 0; v < V; v++) begin : g_vc
            wire [PORT_W-1:0] buf_dest;
            wire              assigned_ready;
            wire              ss_ovc_ready;
            wire              permit;
            wire              vc_wr;

            assign buf_dest = ivc_dest_port_i[v*PORT_W +: PORT_W];

            // packet in flight already owns straight ovc v
            assign assigned_ready = (buf_dest == SS_CODE) & assigned_ovc_num_i[v*V + v]
                                  & ~ovc_full_ss_i[v];
            assign ss_ovc_ready = ovc_is_assigned_i[v] ? assigned_ready : ovc_avail_ss_i[v];

            assign permit = ss_ovc_ready & ~ivc_req_i[v] & port_free;
            assign vc_wr  = flit_in_wr_i & vc_num_i[v];

            assign decreased_credit_o[v]          = credit_pre & vc_wr & permit;
            assign ivc_num_getting_sw_grant_o[v]  = decreased_credit_o[v];
            assign ivc_num_getting_ovc_grant_o[v] = alloc_pre & vc_wr & permit;
            assign ivc_reset_o[v]                 = release_pre & vc_wr & permit;

            // single flit packets never hold the ovc
            assign ovc_allocated_o[v] = ivc_num_getting_ovc_grant_o[v] & ~single_flit_pck_i;
            assign ovc_released_o[v]  = ivc_reset_o[v] & ~single_flit_pck_i;

            // ivc v always maps onto ovc v of the straight port
            for (w = 0; w < V; w++) begin : g_ovc
                assign granted_ovc_num_o[v*V + w] =
                    (w == v) ? ivc_num_getting_ovc_grant_o[v] : 1'b0;
            end
        end
    endgenerate

endmodule

// File: verilog/ssa_port_map.sv
`timescale 1ns/1ps

// moves per-input results onto straight output port slots
// and registers the flit write strobe of each output port
module ssa_port_map
    import ssa_pkg::*;
#(
    parameter int P = P_DEF,
    parameter int V = V_DEF
) (
    input  logic           clk,
    input  logic           arst_n_i,

    // input port indexed
    input  logic [P-1:0]   single_flit_pck_i,
    input  logic [P*V-1:0] ivc_num_getting_sw_grant_i,
    input  logic [P*V-1:0] decreased_credit_i,
    input  logic [P*V-1:0] ovc_allocated_i,
    input  logic [P*V-1:0] ovc_released_i,

    // output port indexed
    output wire  [P*V-1:0] ovc_allocated_o,
    output wire  [P*V-1:0] ovc_released_o,
    output wire  [P*V-1:0] buff_space_decreased_o,

    output wire  [P*V-1:0] ivc_single_flit_pck_o,
    output wire  [P*V-1:0] ovc_single_flit_pck_o,
    output logic [P-1:0]   ssa_flit_wr_o
);

    wire [P-1:0] flit_wr_next;

    genvar c;
    generate
        for (c = 0; c < P; c++) begin : g_port
            localparam int SS = int'(straight_port(P, c));

            if (SS == P) begin : g_local
                // only the local port lacks a straight port
                // so slot c is also the one no input maps onto
                assign ovc_allocated_o[c*V +: V]        = '0;
                assign ovc_released_o[c*V +: V]         = '0;
                assign buff_space_decreased_o[c*V +: V] = '0;
                assign ivc_single_flit_pck_o[c*V +: V]  = '0;
                assign ovc_single_flit_pck_o[c*V +: V]  = '0;
                assign flit_wr_next[c]                  = 1'b0;
            end else begin : g_straight
                // input c lands on output SS
                assign ovc_allocated_o[SS*V +: V]        = ovc_allocated_i[c*V +: V];
                assign ovc_released_o[SS*V +: V]         = ovc_released_i[c*V +: V];
                assign buff_space_decreased_o[SS*V +: V] = decreased_credit_i[c*V +: V];

                assign ivc_single_flit_pck_o[c*V +: V] = {V{single_flit_pck_i[c]}};
                assign ovc_single_flit_pck_o[c*V +: V] = {V{single_flit_pck_i[SS]}};

                // output c is fed by input SS since the mapping is symmetric
                assign flit_wr_next[c] = |ivc_num_getting_sw_grant_i[SS*V +: V];
            end
        end
    endgenerate

    // flit reaches the output buffer one cycle after the bypass grant
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ssa_flit_wr_o <= '0;
        end else begin
            ssa_flit_wr_o <= flit_wr_next;
        end
    end

endmodule

// File: verilog/ss_allocator.sv
`timescale 1ns/1ps

// static straight allocator
// lets a flit skip vc and switch allocation when its straight path is free
module ss_allocator
    import ssa_pkg::*;
#(
    parameter int P = P_DEF,
    parameter int V = V_DEF
) (
    input  logic                  clk,
    input  logic                  arst_n_i,

    input  logic [P-1:0]          flit_in_wr_i,
    input  logic [P*FLIT_W-1:0]   flit_in_i,
    input  logic [P-1:0]          any_ovc_granted_in_outport_i,
    input  logic [P-1:0]          any_ivc_sw_request_granted_i,
    input  logic [P*V-1:0]        ovc_avail_i,
    input  logic [P*V-1:0]        ovc_full_i,
    input  logic [P*V-1:0]        ivc_req_i,
    input  logic [P*V-1:0]        ovc_is_assigned_i,
    input  logic [P*V*V-1:0]      assigned_ovc_num_i,
    input  logic [P*V*PORT_W-1:0] ivc_dest_port_i,    // buffered packet destination

    // output port indexed
    output wire  [P*V-1:0]        ovc_allocated_o,
    output wire  [P*V-1:0]        ovc_released_o,
    output wire  [P*V-1:0]        buff_space_decreased_o,

    // input port indexed
    output wire  [P*V-1:0]        ivc_num_getting_sw_grant_o,
    output wire  [P*V-1:0]        ivc_num_getting_ovc_grant_o,
    output wire  [P*V-1:0]        ivc_reset_o,
    output wire  [P*V-1:0]        ivc_single_flit_pck_o,
    output wire  [P*V-1:0]        ovc_single_flit_pck_o,
    output wire  [P*V*V-1:0]      ivc_granted_ovc_num_o,
    output wire  [P-1:0]          ssa_flit_wr_o
);

    wire [P-1:0]   single_flit_pck;
    wire [P*V-1:0] decreased_credit;
    wire [P*V-1:0] ovc_allocated_iv;   // still input indexed
    wire [P*V-1:0] ovc_released_iv;

    genvar c;
    generate
        for (c = 0; c < P; c++) begin : g_in
            localparam int SS = int'(straight_port(P, c));

            if (SS == P) begin : g_local
                assign ivc_num_getting_sw_grant_o[c*V +: V]    = '0;
                assign ivc_num_getting_ovc_grant_o[c*V +: V]   = '0;
                assign ivc_reset_o[c*V +: V]                   = '0;
                assign ivc_granted_ovc_num_o[c*V*V +: V*V]     = '0;
                assign decreased_credit[c*V +: V]              = '0;
                assign ovc_allocated_iv[c*V +: V]              = '0;
                assign ovc_released_iv[c*V +: V]               = '0;
                assign single_flit_pck[c]                      = 1'b0;
            end else begin : g_ssa
                wire         hdr_flg;
                wire         tail_flg;
                wire [V-1:0] vc_num;
                wire         hdr_to_ss;

                ssa_flit_decode #(
                    .V       (V),
                    .SS_PORT (SS)
                ) u_decode (
                    .flit_in_i         (flit_in_i[c*FLIT_W +: FLIT_W]),
                    .flit_in_wr_i      (flit_in_wr_i[c]),
                    .hdr_flg_o         (hdr_flg),
                    .tail_flg_o        (tail_flg),
                    .single_flit_pck_o (single_flit_pck[c]),
                    .vc_num_o          (vc_num),
                    .hdr_to_ss_o       (hdr_to_ss)
                );

                // output port state is taken from the straight port
                ssa_vc_check #(
                    .V       (V),
                    .SS_PORT (SS)
                ) u_check (
                    .hdr_flg_i                    (hdr_flg),
                    .tail_flg_i                   (tail_flg),
                    .single_flit_pck_i            (single_flit_pck[c]),
                    .vc_num_i                     (vc_num),
                    .hdr_to_ss_i                  (hdr_to_ss),
                    .flit_in_wr_i                 (flit_in_wr_i[c]),
                    .any_ivc_sw_request_granted_i (any_ivc_sw_request_granted_i[c]),
                    .any_ovc_granted_in_ss_port_i (any_ovc_granted_in_outport_i[SS]),
                    .ovc_avail_ss_i               (ovc_avail_i[SS*V +: V]),
                    .ovc_full_ss_i                (ovc_full_i[SS*V +: V]),
                    .ivc_req_i                    (ivc_req_i[c*V +: V]),
                    .ovc_is_assigned_i            (ovc_is_assigned_i[c*V +: V]),
                    .assigned_ovc_num_i           (assigned_ovc_num_i[c*V*V +: V*V]),
                    .ivc_dest_port_i              (ivc_dest_port_i[c*V*PORT_W +: V*PORT_W]),
                    .ivc_num_getting_sw_grant_o   (ivc_num_getting_sw_grant_o[c*V +: V]),
                    .ivc_num_getting_ovc_grant_o  (ivc_num_getting_ovc_grant_o[c*V +: V]),
                    .ivc_reset_o                  (ivc_reset_o[c*V +: V]),
                    .decreased_credit_o           (decreased_credit[c*V +: V]),
                    .ovc_allocated_o              (ovc_allocated_iv[c*V +: V]),
                    .ovc_released_o               (ovc_released_iv[c*V +: V]),
                    .granted_ovc_num_o            (ivc_granted_ovc_num_o[c*V*V +: V*V])
                );
            end
        end
    endgenerate

    ssa_port_map #(
        .P (P),
        .V (V)
    ) u_port_map (
        .clk                        (clk),
        .arst_n_i                   (arst_n_i),
        .single_flit_pck_i          (single_flit_pck),
        .ivc_num_getting_sw_grant_i (ivc_num_getting_sw_grant_o),
        .decreased_credit_i         (decreased_credit),
        .ovc_allocated_i            (ovc_allocated_iv),
        .ovc_released_i             (ovc_released_iv),
        .ovc_allocated_o            (ovc_allocated_o),
        .ovc_released_o             (ovc_released_o),
        .buff_space_decreased_o     (buff_space_decreased_o),
        .ivc_single_flit_pck_o      (ivc_single_flit_pck_o),
        .ovc_single_flit_pck_o      (ovc_single_flit_pck_o),
        .ssa_flit_wr_o              (ssa_flit_wr_o)
    );

endmodule

// File: bench/ssa_asserts.sv
`timescale 1ns/1ps

// properties of the straight allocator outputs bound into ss_allocator
module ssa_asserts
    import ssa_pkg::*;
#(
    parameter int P = P_DEF,
    parameter int V = V_DEF
) (
    input logic             clk,
    input logic             arst_n_i,
    input logic [P*V-1:0]   ivc_num_getting_sw_grant_i,
    input logic [P*V-1:0]   ivc_num_getting_ovc_grant_i,
    input logic [P*V-1:0]   ivc_reset_i,
    input logic [P*V-1:0]   ovc_allocated_i,
    input logic [P*V-1:0]   ovc_released_i,
    input logic [P*V-1:0]   buff_space_decreased_i,
    input logic [P*V*V-1:0] ivc_granted_ovc_num_i,
    input logic [P-1:0]     ssa_flit_wr_i
);

    int fail_count = 0;  // failed assertion attempts so far

    wire local_any = |{ivc_num_getting_sw_grant_i[PORT_LOCAL*V +: V],
                       ivc_num_getting_ovc_grant_i[PORT_LOCAL*V +: V],
                       ivc_reset_i[PORT_LOCAL*V +: V], ovc_allocated_i[PORT_LOCAL*V +: V],
                       ovc_released_i[PORT_LOCAL*V +: V],
                       buff_space_decreased_i[PORT_LOCAL*V +: V], ssa_flit_wr_i[PORT_LOCAL]};

    local_quiet: assert property (@(posedge clk) !local_any)
        else begin
            fail_count++;
            $error("strobe raised on the local port");
        end

    genvar r, s;
    generate
        for (r = 0; r < P*V; r++) begin : g_row
            row_onehot: assert property (@(posedge clk)
                $onehot0(ivc_granted_ovc_num_i[r*V +: V]))
                else begin
                    fail_count++;
                    $error("granted ovc row %0d has more than one bit set", r);
                end
        end

        for (s = 0; s < P; s++) begin : g_out
            localparam int SS = int'(straight_port(P, s));
            if (SS != P) begin : g_straight
                // output s is fed by input SS
                wr_follows: assert property (@(posedge clk) disable iff (!arst_n_i)
                    1'b1 |=> (ssa_flit_wr_i[s] == $past(|ivc_num_getting_sw_grant_i[SS*V +: V])))
                    else begin
                        fail_count++;
                        $error("flit write on port %0d does not follow its switch grant", s);
                    end
                alloc_granted: assert property (@(posedge clk)
                    (ovc_allocated_i[s*V +: V] & ~ivc_num_getting_ovc_grant_i[SS*V +: V]) == '0)
                    else begin
                        fail_count++;
                        $error("ovc allocated on port %0d without a vc grant", s);
                    end
            end
        end
    endgenerate

endmodule

bind ss_allocator ssa_asserts #(
    .P (P),
    .V (V)
) u_asserts (
    .clk                         (clk),
    .arst_n_i                    (arst_n_i),
    .ivc_num_getting_sw_grant_i  (ivc_num_getting_sw_grant_o),
    .ivc_num_getting_ovc_grant_i (ivc_num_getting_ovc_grant_o),
    .ivc_reset_i                 (ivc_reset_o),
    .ovc_allocated_i             (ovc_allocated_o),
    .ovc_released_i              (ovc_released_o),
    .buff_space_decreased_i      (buff_space_decreased_o),
    .ivc_granted_ovc_num_i       (ivc_granted_ovc_num_o),
    .ssa_flit_wr_i               (ssa_flit_wr_o)
);

// File: bench/ssa_model.svh
`ifndef SSA_MODEL_SVH
`define SSA_MODEL_SVH

// reference model, lives inside the testbench module and reads its stimulus signals

// vc v of input c may take the straight path if its output side allows it
function automatic bit bypass_permitted(input int c, input int v);
    int ss;
    bit ready;
    ss = int'(straight_port(P, c));
    if (ovc_is_assigned[c*V+v]) begin
        // packet in flight must already hold straight ovc v
        ready = (ivc_dest_port[(c*V+v)*PORT_W +: PORT_W] == PORT_W'(ss))
              && assigned_ovc_num[(c*V+v)*V + v] && !ovc_full[ss*V+v];
    end else begin
        ready = ovc_avail[ss*V+v];
    end
    return ready && !ivc_req[c*V+v] && !any_ivc_sw_request_granted[c]
        && !any_ovc_granted_in_outport[ss];
endfunction

// fills every exp_ vector from the inputs of this cycle
function automatic void predict_outputs();
    logic [FLIT_W-1:0] flit;
    bit hdr, tail, single, to_ss, go, credit_pre, reset_pre;
    int ss, c, v;
    exp_sw_grant = '0;
    exp_ovc_grant = '0;
    exp_ivc_reset = '0;
    exp_granted_ovc = '0;
    exp_ovc_alloc = '0;
    exp_ovc_release = '0;
    exp_credit = '0;
    exp_ivc_single = '0;
    exp_ovc_single = '0;
    exp_flit_wr_next = '0;
    for (c = 0; c < P; c++) begin
        ss = int'(straight_port(P, c));
        if (ss != P) begin
            flit = flit_in[c*FLIT_W +: FLIT_W];
            hdr = flit[HDR_BIT];
            tail = flit[TAIL_BIT];
            single = hdr && tail;
            to_ss = hdr && (flit[PORT_W-1:0] == PORT_W'(ss));
            credit_pre = !hdr || to_ss;  // headers turning away take no slot
            reset_pre = single ? credit_pre : tail;
            exp_ivc_single[c*V +: V] = {V{single}};
            exp_ovc_single[c*V +: V] =
                {V{flit_in[ss*FLIT_W+HDR_BIT] & flit_in[ss*FLIT_W+TAIL_BIT]}};
            for (v = 0; v < V; v++) begin
                go = flit_in_wr[c] && flit[VC_MSB-V+1+v] && bypass_permitted(c, v);
                exp_sw_grant[c*V+v] = go && credit_pre;
                exp_ovc_grant[c*V+v] = go && to_ss;
                exp_ivc_reset[c*V+v] = go && reset_pre;
                exp_granted_ovc[(c*V+v)*V + v] = go && to_ss;
                exp_credit[ss*V+v] = go && credit_pre;
                exp_ovc_alloc[ss*V+v] = go && to_ss && !single;
                exp_ovc_release[ss*V+v] = go && reset_pre && !single;
            end
        end
    end
    for (c = 0; c < P; c++) begin
        ss = int'(straight_port(P, c));
        if (ss != P) exp_flit_wr_next[c] = |exp_sw_grant[ss*V +: V];
    end
endfunction

`endif

// File: bench/tb_ss_allocator.sv
`timescale 1ns/1ps

// random stimulus on a 5 port mesh router checked against the model each cycle
module tb_ss_allocator
    import ssa_pkg::*;
();

    localparam int P = 5;
    localparam int V = 2;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_CYCLES = 2000;
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + 100;  // reset and start fit in the margin
    localparam logic [31:0] SEED = 32'h57f8_6692;

    logic                  clk;
    logic                  arst_n;
    logic [P-1:0]          flit_in_wr, any_ovc_granted_in_outport, any_ivc_sw_request_granted;
    logic [P*FLIT_W-1:0]   flit_in;
    logic [P*V-1:0]        ovc_avail, ovc_full, ivc_req, ovc_is_assigned;
    logic [P*V*V-1:0]      assigned_ovc_num;
    logic [P*V*PORT_W-1:0] ivc_dest_port;

    wire  [P*V-1:0]   ovc_allocated, ovc_released, buff_space_decreased;
    wire  [P*V-1:0]   sw_grant, ovc_grant, ivc_reset, ivc_single, ovc_single;
    wire  [P*V*V-1:0] granted_ovc;
    wire  [P-1:0]     ssa_flit_wr;

    // expected values from the model
    logic [P*V-1:0]   exp_sw_grant, exp_ovc_grant, exp_ivc_reset, exp_ovc_alloc;
    logic [P*V-1:0]   exp_ovc_release, exp_credit, exp_ivc_single, exp_ovc_single;
    logic [P*V*V-1:0] exp_granted_ovc;
    logic [P-1:0]     exp_flit_wr, exp_flit_wr_next;

    int cycle_count = 0;

    `include "ssa_model.svh"

    ss_allocator #(.P(P), .V(V)) uut (
        .clk (clk), .arst_n_i (arst_n),
        .flit_in_wr_i (flit_in_wr), .flit_in_i (flit_in),
        .any_ovc_granted_in_outport_i (any_ovc_granted_in_outport),
        .any_ivc_sw_request_granted_i (any_ivc_sw_request_granted),
        .ovc_avail_i (ovc_avail), .ovc_full_i (ovc_full), .ivc_req_i (ivc_req),
        .ovc_is_assigned_i (ovc_is_assigned), .assigned_ovc_num_i (assigned_ovc_num),
        .ivc_dest_port_i (ivc_dest_port),
        .ovc_allocated_o (ovc_allocated), .ovc_released_o (ovc_released),
        .buff_space_decreased_o (buff_space_decreased),
        .ivc_num_getting_sw_grant_o (sw_grant), .ivc_num_getting_ovc_grant_o (ovc_grant),
        .ivc_reset_o (ivc_reset), .ivc_single_flit_pck_o (ivc_single),
        .ovc_single_flit_pck_o (ovc_single), .ivc_granted_ovc_num_o (granted_ovc),
        .ssa_flit_wr_o (ssa_flit_wr)
    );

    always #4 clk = ~clk;  // 8 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    function automatic bit chance(input int num, input int den);
        return ($urandom % den) < num;
    endfunction

    function automatic logic [V-1:0] rand_onehot();
        logic [V-1:0] oh;
        oh = '0;
        oh[$urandom % V] = 1'b1;
        return oh;
    endfunction

    // new inputs for all ports biased so bypass happens often
    task automatic drive_random();
        logic [P*FLIT_W-1:0] flits;
        logic [FLIT_W-1:0] f;
        logic [P*V*V-1:0] onum;
        logic [P*V*PORT_W-1:0] dests;
        logic [P*V-1:0] req, avail, full, assigned;
        logic [P-1:0] wr, sw_busy, out_busy;
        int c, v, ss;
        for (c = 0; c < P; c++) begin
            ss = int'(straight_port(P, c));
            f = $urandom;
            f[HDR_BIT] = chance(1, 2);
            f[TAIL_BIT] = chance(1, 2);
            f[VC_MSB -: V] = rand_onehot();
            if (chance(1, 2)) f[PORT_W-1:0] = PORT_W'(ss);  // aim the header straight
            flits[c*FLIT_W +: FLIT_W] = f;
            wr[c] = chance(3, 4);
            sw_busy[c] = chance(1, 4);
            out_busy[c] = chance(1, 4);
            for (v = 0; v < V; v++) begin
                req[c*V+v] = chance(1, 4);
                avail[c*V+v] = chance(3, 4);
                full[c*V+v] = chance(1, 4);
                assigned[c*V+v] = chance(1, 2);
                onum[(c*V+v)*V +: V] = rand_onehot();
                dests[(c*V+v)*PORT_W +: PORT_W] =
                    chance(1, 2) ? PORT_W'(ss) : PORT_W'($urandom % P);
            end
        end
        flit_in_wr <= wr;
        flit_in <= flits;
        any_ivc_sw_request_granted <= sw_busy;
        any_ovc_granted_in_outport <= out_busy;
        ivc_req <= req;
        ovc_avail <= avail;
        ovc_full <= full;
        ovc_is_assigned <= assigned;
        assigned_ovc_num <= onum;
        ivc_dest_port <= dests;
    endtask

    task automatic check_cycle();
        int c, ss;
        if (uut.u_asserts.fail_count != 0) begin
            $display("a bound assertion on uut failed");
            $display(">>> FAIL");
            $fatal(1, "assertion failure");
        end
        predict_outputs();
        check_equal("flit_wr_delay", exp_flit_wr, ssa_flit_wr);
        check_equal("sw_grant", exp_sw_grant, sw_grant);
        check_equal("ovc_grant", exp_ovc_grant, ovc_grant);
        check_equal("ivc_reset", exp_ivc_reset, ivc_reset);
        check_equal("granted_ovc_num", exp_granted_ovc, granted_ovc);
        check_equal("ovc_allocated", exp_ovc_alloc, ovc_allocated);
        check_equal("ovc_released", exp_ovc_release, ovc_released);
        check_equal("buff_space_decreased", exp_credit, buff_space_decreased);
        check_equal("ivc_single_flit", exp_ivc_single, ivc_single);
        check_equal("ovc_single_flit", exp_ovc_single, ovc_single);
        for (c = 0; c < P; c++) begin
            ss = int'(straight_port(P, c));
            if (ss == P) begin
                check_equal("local_quiet", '0, {sw_grant[c*V +: V], ovc_grant[c*V +: V],
                    ivc_reset[c*V +: V], ovc_allocated[c*V +: V], buff_space_decreased[c*V +: V],
                    ivc_single[c*V +: V], ssa_flit_wr[c]});
            end else if (any_ivc_sw_request_granted[c] || any_ovc_granted_in_outport[ss]) begin
                check_equal("blocked_input", '0, {sw_grant[c*V +: V], ovc_grant[c*V +: V],
                    ivc_reset[c*V +: V], granted_ovc[c*V*V +: V*V], ovc_allocated[ss*V +: V],
                    ovc_released[ss*V +: V], buff_space_decreased[ss*V +: V]});
            end
        end
        exp_flit_wr = exp_flit_wr_next;  // register shows this cycle's grants next cycle
    endtask

    initial begin
        void'($urandom(SEED));
        clk = 1'b0;
        arst_n = 1'b0;
        flit_in_wr = '0;
        flit_in = '0;
        any_ovc_granted_in_outport = '0;
        any_ivc_sw_request_granted = '0;
        ovc_avail = '0;
        ovc_full = '0;
        ivc_req = '0;
        ovc_is_assigned = '0;
        assigned_ovc_num = '0;
        ivc_dest_port = '0;
        exp_flit_wr = '0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_equal("reset_flit_wr", '0, ssa_flit_wr);
        end
        @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        drive_random();
        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(negedge clk);
            check_cycle();
            @(posedge clk);
            drive_random();
        end
        @(negedge clk);
        if (uut.u_asserts.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+bench
verilog/ssa_pkg.sv
verilog/ssa_flit_decode.sv
verilog/ssa_vc_check.sv
verilog/ssa_port_map.sv
verilog/ss_allocator.sv
bench/ssa_asserts.sv
bench/tb_ss_allocator.sv
